//--- build.f
sat_pkg.sv
axil_pkg.sv
axil_regs.sv
variable_table.sv
xorshift_prng.sv
flip_controller.sv
walksat_step_top.sv
tb_walksat_step.sv

//--- Makefile
# Verilator simulation of the WalkSAT step testbench
VERILATOR ?= verilator
TOP       ?= tb_walksat_step
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_walksat_step.sv
// WalkSAT step testbench
`timescale 1ns/1ps
`default_nettype none

module tb_walksat_step;
    import sat_pkg::*;
    import axil_pkg::*;

    localparam int          NUM_VARIABLES = 16;
    localparam logic [31:0] PRNG_SEED     = 32'h1234_5678;
    localparam int          WAIT_LIMIT    = 100;   // cycles per wait
    localparam int          RANDOM_STEPS  = 50;

    typedef enum logic [1:0] {F_AWREADY, F_BVALID, F_ARREADY, F_RVALID} flag_t;

    logic      clk = 1'b0;
    logic      rst;
    axil_req_t req;
    axil_rsp_t rsp;

    // reference model
    logic [31:0]              model_rand;
    logic [NUM_VARIABLES-1:0] model_vars;
    logic [FLIP_CNT_W-1:0]    model_flips;
    clause_t                  model_lits;

    string cur_test;
    int    errors;
    int    test_errors;
    int    tests_run;
    int    tests_failed;

    walksat_step_top #(
        .NUM_VARIABLES(NUM_VARIABLES),
        .PRNG_SEED    (PRNG_SEED)
    ) i_walksat_step_top (
        .clk_i     (clk),
        .rst_i     (rst),
        .axil_req_i(req),
        .axil_rsp_o(rsp)
    );

    always #5 clk = ~clk;

    // xorshift32 with shifts 13, 17, 5
    function automatic logic [31:0] xorshift_next(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [AXIL_ADDR_W-1:0] var_addr(input int i);
        return VAR_BASE + 12'(4 * i);
    endfunction

    function automatic logic [AXIL_ADDR_W-1:0] lit_addr(input int k);
        return REG_LIT0 + 12'(4 * k);
    endfunction

    function automatic literal_t make_literal(input logic neg, input int idx);
        return '{neg: neg, var_addr: var_addr_t'(idx)};
    endfunction

    function automatic logic flag_value(input flag_t f);
        case (f)
            F_AWREADY: return rsp.awready;
            F_BVALID:  return rsp.bvalid;
            F_ARREADY: return rsp.arready;
            default:   return rsp.rvalid;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("test %s: %s", cur_test, why);
        $display("ERRORS FOUND");
        $finish;
    endtask

    // sampled on the falling edge, away from the drive edge
    task automatic wait_flag(input flag_t f);
        int n;
        n = 1;
        @(negedge clk);
        while (!flag_value(f) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!flag_value(f)) abort_run({"timed out waiting for ", f.name()});
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error %s: %s expected %h actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hf;
        req.bready  <= 1'b1;
        wait_flag(F_AWREADY);
        check_value("wready", 32'h1, 32'(rsp.wready));
        @(posedge clk);  // AW and W taken here
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        wait_flag(F_BVALID);
        resp = rsp.bresp;
        @(posedge clk);
        req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        req.rready  <= 1'b1;
        wait_flag(F_ARREADY);
        @(posedge clk);
        req.arvalid <= 1'b0;
        wait_flag(F_RVALID);
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        req.rready <= 1'b0;
    endtask

    task automatic write_expect(input string what, input logic [AXIL_ADDR_W-1:0] addr,
                                input logic [31:0] data, input logic [1:0] exp_resp);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_value({what, " bresp"}, 32'(exp_resp), 32'(resp));
    endtask

    task automatic read_expect(input string what, input logic [AXIL_ADDR_W-1:0] addr,
                               input logic [31:0] exp_data, input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_value({what, " rresp"}, 32'(exp_resp), 32'(resp));
        check_value({what, " rdata"}, exp_data, data);
    endtask

    task automatic set_var(input int i, input logic value);
        write_expect($sformatf("var%0d", i), var_addr(i), 32'(value), RESP_OKAY);
        model_vars[i] = value;
    endtask

    task automatic randomize_vars();
        logic [31:0] r;
        for (int i = 0; i < NUM_VARIABLES; i++) begin
            r = $urandom;
            set_var(i, r[0]);
        end
    endtask

    task automatic check_all_vars();
        for (int i = 0; i < NUM_VARIABLES; i++) begin
            read_expect($sformatf("var%0d", i), var_addr(i), 32'(model_vars[i]), RESP_OKAY);
        end
    endtask

    task automatic check_lits();
        for (int k = 0; k < NSAT; k++) begin
            read_expect($sformatf("lit%0d", k), lit_addr(k), 32'(model_lits[k]), RESP_OKAY);
        end
    endtask

    // loads the clause, updates the model, starts a step and polls until idle
    task automatic run_step(input clause_t c, output logic dut_sat);
        logic [NSAT-1:0] lit_true;
        logic            sat;
        logic [31:0]     data;
        logic [1:0]      resp;
        int              sel;
        int              n;
        for (int k = 0; k < NSAT; k++) begin
            write_expect($sformatf("lit%0d", k), lit_addr(k), 32'(c[k]), RESP_OKAY);
            model_lits[k] = c[k];
            lit_true[k]   = model_vars[c[k].var_addr] ^ c[k].neg;
        end
        sat = |lit_true;
        if (!sat) begin
            sel = int'(model_rand % NSAT);
            model_vars[c[sel].var_addr] = ~model_vars[c[sel].var_addr];
            model_flips++;
        end
        model_rand = xorshift_next(model_rand);
        write_expect("ctrl", REG_CTRL, 32'h1, RESP_OKAY);
        n = 0;
        do begin
            axil_read(REG_STATUS, data, resp);
            n++;
        end while (data[0] && n < WAIT_LIMIT);
        if (data[0]) begin
            abort_run("step still busy after the polling limit");
        end else begin
            check_value("status rresp", 32'(RESP_OKAY), 32'(resp));
            check_value("satisfied", 32'(sat), 32'(data[1]));
            dut_sat = data[1];
        end
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", cur_test, errors - test_errors);
        end
    endtask

    initial begin
        logic                  sat;
        logic [31:0]           r;
        logic [FLIP_CNT_W-1:0] flips_before;
        clause_t               c;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "setup";
        void'($urandom(68));
        req <= '0;
        rst <= 1'b1;
        model_rand  = PRNG_SEED;
        model_vars  = '0;
        model_flips = '0;
        model_lits  = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset");
        read_expect("status", REG_STATUS, 32'h0, RESP_OKAY);
        read_expect("flips", REG_FLIPS, 32'h0, RESP_OKAY);
        check_lits();
        check_all_vars();
        check_value("prng seed", PRNG_SEED, i_walksat_step_top.prng_rand);
        end_test();

        begin_test("readback");
        randomize_vars();
        for (int k = 0; k < NSAT; k++) begin
            r = $urandom;
            model_lits[k] = r[LIT_W-1:0];
            write_expect($sformatf("lit%0d", k), lit_addr(k), 32'(model_lits[k]), RESP_OKAY);
        end
        check_all_vars();
        check_lits();
        end_test();

        begin_test("satisfied_step");
        set_var(1, 1'b1);
        set_var(2, 1'b0);
        set_var(3, 1'b0);
        c[0] = make_literal(1'b0, 1);  // true
        c[1] = make_literal(1'b0, 2);
        c[2] = make_literal(1'b0, 3);
        flips_before = model_flips;
        run_step(c, sat);
        check_value("satisfied bit", 32'h1, 32'(sat));
        read_expect("flips", REG_FLIPS, 32'(flips_before), RESP_OKAY);
        check_all_vars();
        check_value("prng state", model_rand, i_walksat_step_top.prng_rand);
        end_test();

        begin_test("flip_step");
        set_var(4, 1'b1);
        set_var(5, 1'b0);
        set_var(6, 1'b1);
        c[0] = make_literal(1'b1, 4);  // every literal false
        c[1] = make_literal(1'b0, 5);
        c[2] = make_literal(1'b1, 6);
        flips_before = model_flips;
        run_step(c, sat);
        check_value("satisfied bit", 32'h0, 32'(sat));
        read_expect("flips", REG_FLIPS, 32'(flips_before + 16'd1), RESP_OKAY);
        check_all_vars();
        run_step(c, sat);  // the flip made one literal true
        check_value("repeat satisfied", 32'h1, 32'(sat));
        read_expect("flips", REG_FLIPS, 32'(flips_before + 16'd1), RESP_OKAY);
        end_test();

        begin_test("slverr");
        write_expect("unmapped", 12'h020, 32'h1, RESP_SLVERR);
        write_expect("status", REG_STATUS, 32'h3, RESP_SLVERR);
        write_expect("flips", REG_FLIPS, 32'hffff, RESP_SLVERR);
        write_expect("var range", var_addr(NUM_VARIABLES), 32'h1, RESP_SLVERR);
        read_expect("unmapped", 12'h020, 32'h0, RESP_SLVERR);
        read_expect("var range", var_addr(NUM_VARIABLES), 32'h0, RESP_SLVERR);
        read_expect("status", REG_STATUS, 32'h2, RESP_OKAY);  // satisfied from last step
        read_expect("flips", REG_FLIPS, 32'(model_flips), RESP_OKAY);
        check_lits();
        check_all_vars();
        check_value("prng state", model_rand, i_walksat_step_top.prng_rand);
        end_test();

        begin_test("random_steps");
        for (int s = 0; s < RANDOM_STEPS; s++) begin
            if (s % 5 == 0) begin
                randomize_vars();
            end
            for (int k = 0; k < NSAT; k++) begin
                r = $urandom;
                c[k] = r[LIT_W-1:0];
                if (r[8]) begin
                    c[k].neg = model_vars[c[k].var_addr];  // bias toward false literals
                end
            end
            run_step(c, sat);
            read_expect("flips", REG_FLIPS, 32'(model_flips), RESP_OKAY);
            check_all_vars();
        end
        check_value("prng state", model_rand, i_walksat_step_top.prng_rand);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- walksat_step_top.sv
// WalkSAT flip step top level
`timescale 1ns/1ps
`default_nettype none

module walksat_step_top #(
    parameter int          NUM_VARIABLES = 16,            // 16 at most
    parameter logic [31:0] PRNG_SEED     = 32'h1234_5678
) (
    input  wire                      clk_i,
    input  wire                      rst_i,
    input  wire axil_pkg::axil_req_t axil_req_i,
    output axil_pkg::axil_rsp_t      axil_rsp_o
);
    import sat_pkg::*;

    step_req_t            step_req;
    step_stat_t           step_stat;
    var_wr_t              host_wr;
    var_wr_t              flip_wr;
    var_addr_t            host_rd_addr;
    logic                 host_rd_value;
    var_addr_t [NSAT-1:0] clause_addr;
    logic [NSAT-1:0]      clause_values;
    logic [31:0]          prng_rand;
    logic                 prng_next;

    axil_regs #(
        .NUM_VARIABLES(NUM_VARIABLES)
    ) i_axil_regs (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .axil_req_i     (axil_req_i),
        .axil_rsp_o     (axil_rsp_o),
        .step_req_o     (step_req),
        .step_stat_i    (step_stat),
        .host_wr_o      (host_wr),
        .host_rd_addr_o (host_rd_addr),
        .host_rd_value_i(host_rd_value)
    );

    variable_table #(
        .NUM_VARIABLES(NUM_VARIABLES)
    ) i_variable_table (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .clause_addr_i  (clause_addr),
        .clause_values_o(clause_values),
        .host_rd_addr_i (host_rd_addr),
        .host_rd_value_o(host_rd_value),
        .host_wr_i      (host_wr),
        .flip_wr_i      (flip_wr)
    );

    xorshift_prng #(
        .PRNG_SEED(PRNG_SEED)
    ) i_xorshift_prng (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .next_i(prng_next),
        .rand_o(prng_rand)
    );

    flip_controller i_flip_controller (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .step_req_i     (step_req),
        .clause_addr_o  (clause_addr),
        .clause_values_i(clause_values),
        .rand_i         (prng_rand),
        .prng_next_o    (prng_next),
        .flip_wr_o      (flip_wr),
        .step_stat_o    (step_stat)
    );

endmodule

`default_nettype wire

//--- flip_controller.sv
// Clause evaluate and flip sequencer
`timescale 1ns/1ps
`default_nettype none

module flip_controller (
    input  wire                                 clk_i,
    input  wire                                 rst_i,
    input  wire sat_pkg::step_req_t             step_req_i,
    output sat_pkg::var_addr_t [sat_pkg::NSAT-1:0] clause_addr_o,
    input  wire [sat_pkg::NSAT-1:0]             clause_values_i,
    input  wire [31:0]                          rand_i,
    output logic                                prng_next_o,
    output sat_pkg::var_wr_t                    flip_wr_o,
    output sat_pkg::step_stat_t                 step_stat_o
);
    import sat_pkg::*;

    localparam int SEL_W = $clog2(NSAT);

    // IDLE is cycle 0 of a step, FETCH cycle 1, EVAL cycle 2
    typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_EVAL} state_t;

    state_t                state_q;
    clause_t               clause_q;
    logic [NSAT-1:0]       values_q;
    logic [NSAT-1:0]       lit_true;
    logic                  sat;
    logic [SEL_W-1:0]      sel;
    logic                  satisfied_q;
    logic [FLIP_CNT_W-1:0] flip_count_q;

    // addresses pass straight through on start so values land in FETCH
    always_comb begin
        for (int k = 0; k < NSAT; k++) begin
            clause_addr_o[k] = (state_q == ST_IDLE) ? step_req_i.clause[k].var_addr
                                                    : clause_q[k].var_addr;
            lit_true[k] = values_q[k] ^ clause_q[k].neg;
        end
    end

    assign sat = |lit_true;
    assign sel = SEL_W'(rand_i % NSAT);  // random literal of the clause

    assign prng_next_o     = (state_q == ST_EVAL);
    assign flip_wr_o.en    = (state_q == ST_EVAL) && !sat;
    assign flip_wr_o.addr  = clause_q[sel].var_addr;
    assign flip_wr_o.value = !values_q[sel];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= ST_IDLE;
            satisfied_q  <= 1'b0;
            flip_count_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE:  if (step_req_i.start) state_q <= ST_FETCH;
                ST_FETCH: state_q <= ST_EVAL;
                ST_EVAL: begin
                    state_q     <= ST_IDLE;
                    satisfied_q <= sat;
                    if (!sat) begin
                        flip_count_q <= flip_count_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == ST_IDLE) && step_req_i.start) begin
            clause_q <= step_req_i.clause;
        end
        if (state_q == ST_FETCH) begin
            values_q <= clause_values_i;
        end
    end

    assign step_stat_o.busy       = (state_q != ST_IDLE);
    assign step_stat_o.satisfied  = satisfied_q;
    assign step_stat_o.flip_count = flip_count_q;

endmodule

`default_nettype wire

//--- xorshift_prng.sv
// Xorshift32 random source
`timescale 1ns/1ps
`default_nettype none

module xorshift_prng #(
    parameter logic [31:0] PRNG_SEED = 32'h1234_5678  // must not be zero
) (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         next_i,
    output logic [31:0] rand_o
);

    logic [31:0] state_q;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] state_d;

    assign s1      = state_q ^ (state_q << 13);
    assign s2      = s1 ^ (s1 >> 17);
    assign state_d = s2 ^ (s2 << 5);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= PRNG_SEED;
        end else if (next_i) begin
            state_q <= state_d;  // one state per step
        end
    end

    assign rand_o = state_q;

endmodule

`default_nettype wire

//--- variable_table.sv
// Variable assignment table
`timescale 1ns/1ps
`default_nettype none

module variable_table #(
    parameter int NUM_VARIABLES = 16
) (
    input  wire                                       clk_i,
    input  wire                                       rst_i,
    input  wire sat_pkg::var_addr_t [sat_pkg::NSAT-1:0] clause_addr_i,
    output logic [sat_pkg::NSAT-1:0]                  clause_values_o,
    input  wire sat_pkg::var_addr_t                   host_rd_addr_i,
    output logic                                      host_rd_value_o,
    input  wire sat_pkg::var_wr_t                     host_wr_i,
    input  wire sat_pkg::var_wr_t                     flip_wr_i
);
    import sat_pkg::*;

    logic [NUM_VARIABLES-1:0] vars_q;
    var_wr_t                  wr;

    assign wr = flip_wr_i.en ? flip_wr_i : host_wr_i;  // flip side has priority

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vars_q <= '0;
        end else if (wr.en && (int'(wr.addr) < NUM_VARIABLES)) begin
            vars_q[wr.addr] <= wr.value;
        end
    end

    // registered read ports, unpopulated indices read 0
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < NSAT; k++) begin
            clause_values_o[k] <= (int'(clause_addr_i[k]) < NUM_VARIABLES)
                                  ? vars_q[clause_addr_i[k]] : 1'b0;
        end
        host_rd_value_o <= (int'(host_rd_addr_i) < NUM_VARIABLES)
                           ? vars_q[host_rd_addr_i] : 1'b0;
    end

endmodule

`default_nettype wire

//--- axil_regs.sv
// AXI4-Lite register slave
`timescale 1ns/1ps
`default_nettype none

module axil_regs #(
    parameter int NUM_VARIABLES = 16
) (
    input  wire                      clk_i,
    input  wire                      rst_i,
    input  wire axil_pkg::axil_req_t axil_req_i,
    output axil_pkg::axil_rsp_t      axil_rsp_o,
    output sat_pkg::step_req_t       step_req_o,
    input  wire sat_pkg::step_stat_t step_stat_i,
    output sat_pkg::var_wr_t         host_wr_o,
    output sat_pkg::var_addr_t       host_rd_addr_o,
    input  wire                      host_rd_value_i
);
    import sat_pkg::*;
    import axil_pkg::*;

    localparam int VAR_LSB = 2;
    localparam int VAR_MSB = VAR_LSB + VAR_ADDR_W;

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_RESP} rd_state_t;

    wr_state_t              wr_state_q;
    rd_state_t              rd_state_q;
    clause_t                lit_q;
    logic [AXIL_ADDR_W-1:0] ar_addr_q;
    logic [AXIL_DATA_W-1:0] rdata_q;
    logic [AXIL_DATA_W-1:0] rd_data;
    logic [1:0]             bresp_q;
    logic [1:0]             rresp_q;
    logic [1:0]             wr_resp;
    logic [1:0]             rd_resp;
    logic                   wr_fire;
    logic                   ar_fire;
    logic                   ctrl_we;
    logic                   var_we;
    logic [NSAT-1:0]        lit_we;

    // word-aligned hit inside the populated part of the variable window
    function automatic logic var_hit(input logic [AXIL_ADDR_W-1:0] addr);
        return (addr[AXIL_ADDR_W-1:VAR_MSB] == VAR_BASE[AXIL_ADDR_W-1:VAR_MSB])
            && (addr[VAR_LSB-1:0] == '0)
            && (int'(addr[VAR_MSB-1:VAR_LSB]) < NUM_VARIABLES);
    endfunction

    // AW and W are taken together, never during a step
    assign wr_fire = (wr_state_q == WR_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid
                     && !step_stat_i.busy;
    assign ar_fire = (rd_state_q == RD_IDLE) && axil_req_i.arvalid;

    always_comb begin
        wr_resp = RESP_OKAY;
        ctrl_we = 1'b0;
        var_we  = 1'b0;
        lit_we  = '0;
        case (axil_req_i.awaddr)
            REG_CTRL: ctrl_we   = 1'b1;
            REG_LIT0: lit_we[0] = 1'b1;
            REG_LIT1: lit_we[1] = 1'b1;
            REG_LIT2: lit_we[2] = 1'b1;
            default: begin
                if (var_hit(axil_req_i.awaddr)) begin
                    var_we = 1'b1;
                end else begin
                    wr_resp = RESP_SLVERR;  // unmapped or read-only
                end
            end
        endcase
    end

    assign step_req_o.start  = wr_fire && ctrl_we && axil_req_i.wdata[0];
    assign step_req_o.clause = lit_q;

    assign host_wr_o.en    = wr_fire && var_we;
    assign host_wr_o.addr  = axil_req_i.awaddr[VAR_MSB-1:VAR_LSB];
    assign host_wr_o.value = axil_req_i.wdata[0];

    // address goes out in the AR cycle, table data is back in RD_WAIT
    assign host_rd_addr_o = axil_req_i.araddr[VAR_MSB-1:VAR_LSB];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_state_q <= WR_IDLE;
            lit_q      <= '0;
        end else begin
            case (wr_state_q)
                WR_IDLE: if (wr_fire) wr_state_q <= WR_RESP;
                WR_RESP: if (axil_req_i.bready) wr_state_q <= WR_IDLE;
                default: wr_state_q <= WR_IDLE;
            endcase
            for (int k = 0; k < NSAT; k++) begin
                if (wr_fire && lit_we[k]) begin
                    lit_q[k] <= literal_t'(axil_req_i.wdata[LIT_W-1:0]);
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            bresp_q <= wr_resp;
        end
    end

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (ar_addr_q)
            REG_CTRL:   rd_data = '0;  // strobe only
            REG_STATUS: rd_data[1:0] = {step_stat_i.satisfied, step_stat_i.busy};
            REG_FLIPS:  rd_data[FLIP_CNT_W-1:0] = step_stat_i.flip_count;
            REG_LIT0:   rd_data[LIT_W-1:0] = lit_q[0];
            REG_LIT1:   rd_data[LIT_W-1:0] = lit_q[1];
            REG_LIT2:   rd_data[LIT_W-1:0] = lit_q[2];
            default: begin
                if (var_hit(ar_addr_q)) begin
                    rd_data[0] = host_rd_value_i;
                end else begin
                    rd_resp = RESP_SLVERR;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_state_q <= RD_IDLE;
        end else begin
            case (rd_state_q)
                RD_IDLE: if (ar_fire) rd_state_q <= RD_WAIT;
                RD_WAIT: rd_state_q <= RD_RESP;
                RD_RESP: if (axil_req_i.rready) rd_state_q <= RD_IDLE;
                default: rd_state_q <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_fire) begin
            ar_addr_q <= axil_req_i.araddr;
        end
        if (rd_state_q == RD_WAIT) begin  // snapshot, held while stalled
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_fire;
        axil_rsp_o.wready  = wr_fire;
        axil_rsp_o.bvalid  = (wr_state_q == WR_RESP);
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.arready = ar_fire;
        axil_rsp_o.rvalid  = (rd_state_q == RD_RESP);
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
    end

endmodule

`default_nettype wire

//--- axil_pkg.sv
// AXI4-Lite bus and register map
`default_nettype none

package axil_pkg;

    localparam int AXIL_ADDR_W = 12;
    localparam int AXIL_DATA_W = 32;

    typedef struct packed {
        logic                     awvalid;
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     wvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;    // not used, full-word writes only
        logic                     bready;
        logic                     arvalid;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // register map
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 12'h000;  // bit0 starts a step
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 12'h004;  // {satisfied, busy}
    localparam logic [AXIL_ADDR_W-1:0] REG_FLIPS  = 12'h008;
    localparam logic [AXIL_ADDR_W-1:0] REG_LIT0   = 12'h010;
    localparam logic [AXIL_ADDR_W-1:0] REG_LIT1   = 12'h014;
    localparam logic [AXIL_ADDR_W-1:0] REG_LIT2   = 12'h018;
    localparam logic [AXIL_ADDR_W-1:0] VAR_BASE   = 12'h100;  // one word per variable

endpackage

`default_nettype wire

//--- sat_pkg.sv
// SAT solver types
`default_nettype none

package sat_pkg;

    localparam int NSAT       = 3;               // literals per clause
    localparam int VAR_ADDR_W = 4;
    localparam int LIT_W      = VAR_ADDR_W + 1;  // neg bit on top of the index
    localparam int FLIP_CNT_W = 16;

    typedef logic [VAR_ADDR_W-1:0] var_addr_t;

    // literal is true when value ^ neg is 1
    typedef struct packed {
        logic      neg;
        var_addr_t var_addr;
    } literal_t;

    typedef literal_t [NSAT-1:0] clause_t;

    typedef struct packed {
        logic      en;
        var_addr_t addr;
        logic      value;
    } var_wr_t;

    typedef struct packed {
        logic    start;   // single-cycle pulse
        clause_t clause;
    } step_req_t;

    typedef struct packed {
        logic                  busy;
        logic                  satisfied;  // result before the flip
        logic [FLIP_CNT_W-1:0] flip_count;
    } step_stat_t;

endpackage

`default_nettype wire
